//--- rtl/gm_pkg.sv
`default_nettype none

package gm_pkg;

  // Colour channel width.
  localparam int BPP = 8;

  // Wishbone bus geometry.
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  localparam int WB_SW = WB_DW / 8;

  // Horizontal raster, in video clocks.
  localparam int H_ACTIVE = 128;
  localparam int H_FP     = 8;
  localparam int H_SYNC   = 16;
  localparam int H_BP     = 8;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

  // Vertical raster, in lines.
  localparam int V_ACTIVE = 16;
  localparam int V_FP     = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 4;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

  localparam int H_CNT_W = $clog2(H_TOTAL);
  localparam int V_CNT_W = $clog2(V_TOTAL);

  // One bit per pixel, packed MSB first into bus words.
  localparam int PIX_PER_WORD   = 32;
  localparam int PIX_IDX_W      = $clog2(PIX_PER_WORD);
  localparam int WORDS_PER_LINE = H_ACTIVE / PIX_PER_WORD;
  localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);
  localparam int LINE_STRIDE    = WORDS_PER_LINE * (WB_DW / 8);

  // Two lines of buffering.
  localparam int FIFO_AW = 3;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_SW-1:0] sel;
    logic [WB_AW-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [BPP-1:0] red;
    logic [BPP-1:0] green;
    logic [BPP-1:0] blue;
  } rgb_t;

endpackage

`default_nettype wire

//--- rtl/vga_timing.sv
`timescale 1ns/100ps
`default_nettype none

module vga_timing
  import gm_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  output logic hs_o,
  output logic vs_o,
  output logic h_active_o,
  output logic v_active_o,
  output logic fetch_req_o,
  output logic frame_start_o
);

  logic [H_CNT_W-1:0] h_cnt;
  logic [V_CNT_W-1:0] v_cnt;
  logic               h_last;
  logic               v_last;
  logic               in_hsync;
  logic               in_vsync;
  logic               fetch_line;

  assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
  assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

  assign in_hsync = (h_cnt >= H_CNT_W'(H_ACTIVE + H_FP)) &&
                    (h_cnt <  H_CNT_W'(H_ACTIVE + H_FP + H_SYNC));
  assign in_vsync = (v_cnt >= V_CNT_W'(V_ACTIVE + V_FP)) &&
                    (v_cnt <  V_CNT_W'(V_ACTIVE + V_FP + V_SYNC));

  // Lines whose successor is visible.
  assign fetch_line = v_last || (v_cnt < V_CNT_W'(V_ACTIVE - 1));

  // Start in the front porch so line 0 is prefetched before it is shown.
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      h_cnt <= '0;
      v_cnt <= V_CNT_W'(V_ACTIVE);
    end
    else if (h_last)
    begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + 1'b1;
    end
    else
    begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      hs_o          <= 1'b1;
      vs_o          <= 1'b1;
      h_active_o    <= 1'b0;
      v_active_o    <= 1'b0;
      fetch_req_o   <= 1'b0;
      frame_start_o <= 1'b0;
    end
    else
    begin
      hs_o          <= ~in_hsync;
      vs_o          <= ~in_vsync;
      h_active_o    <= (h_cnt < H_CNT_W'(H_ACTIVE));
      v_active_o    <= (v_cnt < V_CNT_W'(V_ACTIVE));
      // End of the active part of the line.
      fetch_req_o   <= fetch_line && (h_cnt == H_CNT_W'(H_ACTIVE - 1));
      frame_start_o <= (h_cnt == '0) && (v_cnt == V_CNT_W'(V_ACTIVE + V_FP));
    end
  end

  a_hsync_width: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(hs_o) |-> (!hs_o) [*H_SYNC] ##1 hs_o);

  a_fetch_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    fetch_req_o |=> !fetch_req_o);

endmodule

`default_nettype wire

//--- rtl/async_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module async_fifo #(
  parameter int AW = 3
) (
  input  logic        wclk_i,
  input  logic        wrst_i,
  input  logic        wr_en_i,
  input  logic [31:0] wr_data_i,
  output logic        full_o,
  input  logic        rclk_i,
  input  logic        rrst_i,
  input  logic        rd_en_i,
  output logic [31:0] rd_data_o,
  output logic        empty_o
);

  logic [31:0] mem [0:(1 << AW) - 1];

  logic [AW:0] wbin;
  logic [AW:0] wbin_next;
  logic [AW:0] wgray;
  logic [AW:0] wq1_rgray;
  logic [AW:0] wq2_rgray;
  logic        wr_ok;

  logic [AW:0] rbin;
  logic [AW:0] rbin_next;
  logic [AW:0] rgray;
  logic [AW:0] rq1_wgray;
  logic [AW:0] rq2_wgray;
  logic        rd_ok;

  // Write side.
  assign wr_ok     = wr_en_i & ~full_o;
  assign wbin_next = wbin + 1'b1;

  // Full when the pointers differ only in the wrap bits.
  assign full_o = (wgray == {~wq2_rgray[AW:AW-1], wq2_rgray[AW-2:0]});

  always_ff @(posedge wclk_i)
  begin
    if (wr_ok)
      mem[wbin[AW-1:0]] <= wr_data_i;
  end

  always_ff @(posedge wclk_i or posedge wrst_i)
  begin
    if (wrst_i)
    begin
      wbin      <= '0;
      wgray     <= '0;
      wq1_rgray <= '0;
      wq2_rgray <= '0;
    end
    else
    begin
      wq1_rgray <= rgray;
      wq2_rgray <= wq1_rgray;
      if (wr_ok)
      begin
        wbin  <= wbin_next;
        wgray <= wbin_next ^ (wbin_next >> 1);
      end
    end
  end

  // Read side.
  assign rd_ok     = rd_en_i & ~empty_o;
  assign rbin_next = rbin + 1'b1;
  assign empty_o   = (rgray == rq2_wgray);

  // Head word, valid whenever not empty.
  assign rd_data_o = mem[rbin[AW-1:0]];

  always_ff @(posedge rclk_i or posedge rrst_i)
  begin
    if (rrst_i)
    begin
      rbin      <= '0;
      rgray     <= '0;
      rq1_wgray <= '0;
      rq2_wgray <= '0;
    end
    else
    begin
      rq1_wgray <= wgray;
      rq2_wgray <= rq1_wgray;
      if (rd_ok)
      begin
        rbin  <= rbin_next;
        rgray <= rbin_next ^ (rbin_next >> 1);
      end
    end
  end

  a_no_overflow: assert property (@(posedge wclk_i) disable iff (wrst_i)
    wr_en_i |-> !full_o);

  a_no_underflow: assert property (@(posedge rclk_i) disable iff (rrst_i)
    rd_en_i |-> !empty_o);

endmodule

`default_nettype wire

//--- rtl/line_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module line_fetch
  import gm_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             fetch_tgl_i,
  input  logic             frame_tgl_i,
  output wb_req_t          wb_req_o,
  input  wb_rsp_t          wb_rsp_i,
  input  logic             fifo_full_i,
  output logic             fifo_wr_o,
  output logic [WB_DW-1:0] fifo_data_o
);

  // S_ACK is the one cycle with stb low after each accepted word.
  typedef enum logic [1:0] {
    S_IDLE,
    S_STROBE,
    S_ACK
  } state_t;

  state_t                state;
  logic [2:0]            fetch_sync;
  logic [2:0]            frame_sync;
  logic                  fetch_edge;
  logic                  frame_edge;
  logic                  ack_taken;
  logic                  last_word;
  logic [WORD_IDX_W-1:0] idx;
  logic [WB_AW-1:0]      line_addr;

  // Two sync flops, the third keeps the previous value.
  assign fetch_edge = fetch_sync[2] ^ fetch_sync[1];
  assign frame_edge = frame_sync[2] ^ frame_sync[1];

  // Strobe held off while the FIFO has no room.
  assign wb_req_o.cyc = (state != S_IDLE);
  assign wb_req_o.stb = (state == S_STROBE) && !fifo_full_i;
  assign wb_req_o.we  = 1'b0;
  assign wb_req_o.sel = '1;
  assign wb_req_o.adr = line_addr + {{(WB_AW - WORD_IDX_W - 2){1'b0}}, idx, 2'b00};

  assign ack_taken = wb_req_o.stb & wb_rsp_i.ack;
  assign last_word = (idx == WORD_IDX_W'(WORDS_PER_LINE - 1));

  assign fifo_wr_o   = ack_taken;
  assign fifo_data_o = wb_rsp_i.dat;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      fetch_sync <= '0;
      frame_sync <= '0;
    end
    else
    begin
      fetch_sync <= {fetch_sync[1:0], fetch_tgl_i};
      frame_sync <= {frame_sync[1:0], frame_tgl_i};
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state     <= S_IDLE;
      idx       <= '0;
      line_addr <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (fetch_edge)
          begin
            idx   <= '0;
            state <= S_STROBE;
          end
        end
        S_STROBE:
        begin
          if (ack_taken)
          begin
            if (last_word)
            begin
              state     <= S_IDLE;
              line_addr <= line_addr + WB_AW'(LINE_STRIDE);
            end
            else
            begin
              idx   <= idx + 1'b1;
              state <= S_ACK;
            end
          end
        end
        S_ACK:
          state <= S_STROBE;
        default:
          state <= S_IDLE;
      endcase

      // New frame restarts at the top of the framebuffer.
      if (frame_edge)
        line_addr <= '0;
    end
  end

  a_adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o.adr)));

endmodule

`default_nettype wire

//--- rtl/pixel_shift.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_shift
  import gm_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             h_active_i,
  input  logic             v_active_i,
  input  logic             fifo_empty_i,
  input  logic [WB_DW-1:0] fifo_data_i,
  output logic             fifo_rd_o,
  output logic             blank_n_o,
  output rgb_t             rgb_o
);

  logic                 active;
  logic                 first;
  logic                 pix;
  logic [PIX_IDX_W-1:0] pos;
  logic [WB_DW-1:0]     shreg;

  assign active    = h_active_i & v_active_i;
  assign first     = active && (pos == '0);
  assign fifo_rd_o = first && !fifo_empty_i;

  // First pixel comes straight from the FIFO head, the rest from the shifter.
  always_comb
  begin
    if (first)
      pix = fifo_data_i[WB_DW-1] & ~fifo_empty_i;
    else
      pix = shreg[WB_DW-1];
  end

  always_ff @(posedge clk_i)
  begin
    if (first)
      shreg <= fifo_empty_i ? '0 : (fifo_data_i << 1);
    else
      shreg <= shreg << 1;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pos       <= '0;
      blank_n_o <= 1'b0;
      rgb_o     <= '0;
    end
    else
    begin
      pos       <= active ? pos + 1'b1 : '0;
      blank_n_o <= active;
      rgb_o     <= (active && pix) ? '1 : '0;
    end
  end

  // Line data must have crossed over before the group starts.
  a_no_underrun: assert property (@(posedge clk_i) disable iff (rst_i)
    first |-> !fifo_empty_i);

endmodule

`default_nettype wire

//--- rtl/gm_mono.sv
`timescale 1ns/100ps
`default_nettype none

module gm_mono
  import gm_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    video_clk_i,
  input  logic    video_rst_i,
  output wb_req_t wb_req_o,
  input  wb_rsp_t wb_rsp_i,
  output logic    hs_o,
  output logic    vs_o,
  output logic    blank_n_o,
  output rgb_t    rgb_o
);

  logic             h_active;
  logic             v_active;
  logic             fetch_req;
  logic             frame_start;
  logic             fetch_tgl;
  logic             frame_tgl;
  logic             fifo_full;
  logic             fifo_wr;
  logic [WB_DW-1:0] fifo_wdata;
  logic             fifo_empty;
  logic             fifo_rd;
  logic [WB_DW-1:0] fifo_rdata;

  vga_timing i_timing (
    .clk_i         (video_clk_i),
    .rst_i         (video_rst_i),
    .hs_o          (hs_o),
    .vs_o          (vs_o),
    .h_active_o    (h_active),
    .v_active_o    (v_active),
    .fetch_req_o   (fetch_req),
    .frame_start_o (frame_start)
  );

  // Pulses become toggles so they survive the slow-to-fast crossing.
  always_ff @(posedge video_clk_i or posedge video_rst_i)
  begin
    if (video_rst_i)
    begin
      fetch_tgl <= 1'b0;
      frame_tgl <= 1'b0;
    end
    else
    begin
      if (fetch_req)
        fetch_tgl <= ~fetch_tgl;
      if (frame_start)
        frame_tgl <= ~frame_tgl;
    end
  end

  line_fetch i_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fetch_tgl_i (fetch_tgl),
    .frame_tgl_i (frame_tgl),
    .wb_req_o    (wb_req_o),
    .wb_rsp_i    (wb_rsp_i),
    .fifo_full_i (fifo_full),
    .fifo_wr_o   (fifo_wr),
    .fifo_data_o (fifo_wdata)
  );

  async_fifo #(
    .AW (FIFO_AW)
  ) i_fifo (
    .wclk_i    (clk_i),
    .wrst_i    (rst_i),
    .wr_en_i   (fifo_wr),
    .wr_data_i (fifo_wdata),
    .full_o    (fifo_full),
    .rclk_i    (video_clk_i),
    .rrst_i    (video_rst_i),
    .rd_en_i   (fifo_rd),
    .rd_data_o (fifo_rdata),
    .empty_o   (fifo_empty)
  );

  pixel_shift i_shift (
    .clk_i        (video_clk_i),
    .rst_i        (video_rst_i),
    .h_active_i   (h_active),
    .v_active_i   (v_active),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_rdata),
    .fifo_rd_o    (fifo_rd),
    .blank_n_o    (blank_n_o),
    .rgb_o        (rgb_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // Released on a rising edge, like any other stimulus.
  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb/wb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_model
  import gm_pkg::*;
#(
  parameter int MEM_WORDS = 128
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [2:0] wait_i,
  input  wb_req_t    req_i,
  output wb_rsp_t    rsp_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  // Filled by the testbench top before the first access.
  logic [WB_DW-1:0] mem [0:MEM_WORDS-1];

  // Byte address of every acked read, in order.
  logic [WB_AW-1:0] read_log [$];

  logic       busy     = 1'b0;
  logic [2:0] wait_cnt = '0;
  wb_rsp_t    rsp_q    = '0;

  assign rsp_o = rsp_q;

  always @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy     <= 1'b0;
      wait_cnt <= '0;
      rsp_q    <= '0;
    end
    else if (rsp_q.ack)
    begin
      // One ack per strobe.
      rsp_q.ack <= 1'b0;
      busy      <= 1'b0;
    end
    else if (req_i.cyc && req_i.stb && !req_i.we)
    begin
      if (!busy)
      begin
        // New strobe picks its wait states.
        busy     <= 1'b1;
        wait_cnt <= wait_i;
      end
      else if (wait_cnt != '0)
      begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      else
      begin
        rsp_q.ack <= 1'b1;
        rsp_q.dat <= mem[req_i.adr[2 +: IDX_W]];
        read_log.push_back(req_i.adr);
      end
    end
    else
    begin
      // Strobe withdrawn, the next one starts over.
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_gm_mono.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gm_mono
  import gm_pkg::*;
();

  localparam int          MEM_WORDS  = 128;
  localparam int          FRAME_CLKS = V_TOTAL * H_TOTAL;
  // Three frames and a tenth of margin.
  localparam int          TIMEOUT    = (3 * FRAME_CLKS * 11) / 10;
  localparam logic [31:0] SEED       = 32'h32106ed4;

  logic       sys_clk;
  logic       sys_rst;
  logic       video_clk;
  logic       video_rst;
  wb_req_t    bus_req;
  wb_rsp_t    bus_rsp;
  logic       hs;
  logic       vs;
  logic       blank_n;
  rgb_t       rgb;
  logic [2:0] wait_sel = '0;

  logic [31:0] lcg_state = SEED;

  // Monitor state.
  logic sys_rst_d    = 1'b0;
  logic video_rst_d  = 1'b0;
  logic hs_prev      = 1'b1;
  logic vs_prev      = 1'b1;
  logic blank_prev   = 1'b0;
  logic have_hs_fall = 1'b0;
  int   hs_low       = 0;
  int   vs_low       = 0;
  int   line_clks    = 0;
  int   px_x         = 0;
  int   px_y         = 0;
  int   vs_falls     = 0;
  int   bus_words    = 0;
  int   frame_words  = 0;

  tb_clk_gen #(
    .PERIOD_NS  (4.0),
    .RST_CYCLES (2)
  ) i_sys_clk (
    .clk_o (sys_clk),
    .rst_o (sys_rst)
  );

  tb_clk_gen #(
    .PERIOD_NS  (10.0),
    .RST_CYCLES (2)
  ) i_video_clk (
    .clk_o (video_clk),
    .rst_o (video_rst)
  );

  gm_mono i_dut (
    .clk_i       (sys_clk),
    .rst_i       (sys_rst),
    .video_clk_i (video_clk),
    .video_rst_i (video_rst),
    .wb_req_o    (bus_req),
    .wb_rsp_i    (bus_rsp),
    .hs_o        (hs),
    .vs_o        (vs),
    .blank_n_o   (blank_n),
    .rgb_o       (rgb)
  );

  wb_mem_model #(
    .MEM_WORDS (MEM_WORDS)
  ) i_mem (
    .clk_i  (sys_clk),
    .rst_i  (sys_rst),
    .wait_i (wait_sel),
    .req_i  (bus_req),
    .rsp_o  (bus_rsp)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Pixel from the framebuffer, MSB of each word first.
  function automatic rgb_t expected_pixel(input int x, input int y);
    logic [WB_DW-1:0] word;
    logic             bit_on;
    word   = i_mem.mem[(LINE_STRIDE * y + 4 * (x / PIX_PER_WORD)) / 4];
    bit_on = word[PIX_PER_WORD - 1 - (x % PIX_PER_WORD)];
    return {3 * BPP{bit_on}};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_req(input string name, input wb_req_t exp, input wb_req_t act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_sync(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("[ERROR] %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic verify_count(input string name, input int exp, input int act);
    if (act != exp)
      abort_run($sformatf("[ERROR] %s: expected %0h, got %0h", name, exp, act));
  endtask

  // Called on each falling edge of vs_o.
  task automatic close_frame();
    int exp_lines;
    int exp_reads;
    // Nothing is shown or fetched before the first vsync.
    exp_lines = (vs_falls == 0) ? 0 : V_ACTIVE;
    exp_reads = exp_lines * WORDS_PER_LINE;
    verify_count("active lines per frame", exp_lines, px_y);
    verify_count("reads per frame", exp_reads, bus_words - frame_words);
    verify_count("read log length", exp_reads, i_mem.read_log.size());
    for (int i = 0; i < i_mem.read_log.size(); i++)
      verify_count("read log address", 4 * i, i_mem.read_log[i]);
    i_mem.read_log.delete();
    frame_words = bus_words;
    px_y        = 0;
    vs_falls    = vs_falls + 1;
  endtask

  // Fresh wait-state draw every sys clock.
  always @(posedge sys_clk)
  begin
    wait_sel <= 3'(lcg_next() >> 29);
  end

  always @(posedge sys_clk)
  begin : bus_monitor
    wb_req_t exp_req;
    if (sys_rst_d)
    begin
      check_sync("wb_req_o.cyc", 1'b0, bus_req.cyc);
      check_sync("wb_req_o.stb", 1'b0, bus_req.stb);
    end
    else if (!sys_rst && bus_req.stb)
    begin
      // Address tracks the word count, so it cannot move before ack.
      exp_req.cyc = 1'b1;
      exp_req.stb = 1'b1;
      exp_req.we  = 1'b0;
      exp_req.sel = '1;
      exp_req.adr = WB_AW'(4 * (bus_words - frame_words));
      check_req("wb_req_o", exp_req, bus_req);
      if (bus_rsp.ack)
        bus_words = bus_words + 1;
    end
    sys_rst_d = sys_rst;
  end

  always @(posedge video_clk)
  begin : video_monitor
    if (video_rst_d)
    begin
      check_sync("hs_o", 1'b1, hs);
      check_sync("vs_o", 1'b1, vs);
      check_sync("blank_n_o", 1'b0, blank_n);
      check_rgb("rgb_o in reset", rgb_t'('0), rgb);
    end
    else if (!video_rst)
    begin
      // Horizontal sync width and line period.
      if (!hs)
        hs_low = hs_low + 1;
      if (hs && !hs_prev)
      begin
        verify_count("hs_o low cycles", H_SYNC, hs_low);
        hs_low = 0;
      end
      if (!hs && hs_prev)
      begin
        if (have_hs_fall)
          verify_count("line period", H_TOTAL, line_clks);
        have_hs_fall = 1'b1;
        line_clks    = 1;
      end
      else
      begin
        line_clks = line_clks + 1;
      end

      // Vertical sync width and frame bookkeeping.
      if (!vs)
        vs_low = vs_low + 1;
      if (vs && !vs_prev)
      begin
        verify_count("vs_o low cycles", V_SYNC * H_TOTAL, vs_low);
        vs_low = 0;
      end
      if (!vs && vs_prev)
        close_frame();

      // Every frame is held against the same memory image.
      if (blank_n)
      begin
        if (px_x >= H_ACTIVE || px_y >= V_ACTIVE)
        begin
          abort_run("active video appeared outside the visible area");
        end
        else
        begin
          check_rgb($sformatf("rgb_o at x=%0d y=%0d", px_x, px_y),
                    expected_pixel(px_x, px_y), rgb);
          px_x = px_x + 1;
        end
      end
      else
      begin
        check_rgb("rgb_o during blanking", rgb_t'('0), rgb);
        if (blank_prev)
        begin
          verify_count("active pixels per line", H_ACTIVE, px_x);
          px_x = 0;
          px_y = px_y + 1;
        end
      end
    end
    hs_prev     = hs;
    vs_prev     = vs;
    blank_prev  = blank_n;
    video_rst_d = video_rst;
  end

  initial
  begin : main
    int cycles;
    cycles = 0;
    for (int i = 0; i < MEM_WORDS; i++)
      i_mem.mem[i] = lcg_next();
    // Third vs fall closes the second full frame.
    while (vs_falls < 3 && cycles < TIMEOUT)
    begin
      @(posedge video_clk);
      cycles = cycles + 1;
    end
    if (vs_falls >= 3)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      abort_run($sformatf("timeout: two full frames were not seen within %0d video clocks",
                          TIMEOUT));
    end
  end

endmodule

`default_nettype wire

//--- list.f
rtl/gm_pkg.sv
rtl/vga_timing.sv
rtl/async_fifo.sv
rtl/line_fetch.sv
rtl/pixel_shift.sv
rtl/gm_mono.sv
tb/tb_clk_gen.sv
tb/wb_mem_model.sv
tb/tb_gm_mono.sv

//--- Bender.yml
package:
  name: gm_mono

sources:
  - files:
      - rtl/gm_pkg.sv
      - rtl/vga_timing.sv
      - rtl/async_fifo.sv
      - rtl/line_fetch.sv
      - rtl/pixel_shift.sv
      - rtl/gm_mono.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/wb_mem_model.sv
      - tb/tb_gm_mono.sv
